// ==== design/ft_buf_pkg.sv ====
/* buffer-side definitions for the FIFO master
   endpoint count, buffer depth, pointer and RAM address types */

package ft_buf_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int NUM_EP    = 4;                 // channels on the bridge
  localparam int EP_DEPTH  = 8;                 // words per endpoint buffer
  localparam int EP_AW     = $clog2(EP_DEPTH);  // word index bits
  localparam int EP_NW     = $clog2(NUM_EP);    // endpoint number bits
  localparam int RAM_WORDS = NUM_EP * EP_DEPTH;

  // endpoint number
  typedef logic [EP_NW-1:0] ep_t;

  // index plus wrap bit
  typedef logic [EP_AW:0] ptr_t;

  // {endpoint, word index} into the shared RAM
  typedef logic [EP_NW+EP_AW-1:0] ram_adr_t;

  // fill state of one buffer
  typedef struct packed {
    logic empty;
    logic full;
  } ep_stat_t;

endpackage

// ==== design/ft_bus_pkg.sv ====
/* bus-side definitions for the FT600 style FIFO bus
   data and byte enable words, command word layout, direction codes */

package ft_bus_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;         // one enable per byte lane
  localparam int CMD_HI_W = 24;               // upper reserved field
  localparam int CMD_LO_W = DATA_W - CMD_HI_W - 1 - ft_buf_pkg::EP_NW;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // unit moved on the bus and kept in the RAM
  typedef struct packed {
    data_t data;
    be_t   be;
  } bus_word_t;

  // transfer direction as seen from the master
  typedef logic dir_t;
  localparam dir_t DIR_RD = 1'b0;  // slave to master
  localparam dir_t DIR_WR = 1'b1;  // master to slave

  // command word driven in the command phase
  typedef struct packed {
    logic [CMD_HI_W-1:0] rsvd_hi;  // held at zero
    logic [CMD_LO_W-1:0] rsvd_lo;  // held at zero
    dir_t                dir;
    ft_buf_pkg::ep_t     ep;
  } cmd_t;

endpackage

// ==== design/fifo_mst_arb.sv ====
/* round-robin arbiter that picks the next endpoint and transfer direction
   from slave status and buffer fill state while the bus is idle */

module fifo_mst_arb (
  input  logic                                 i_clk,
  input  logic                                 i_reset,
  input  logic                                 i_idle,
  input  logic [2*ft_buf_pkg::NUM_EP-1:0]      i_slv_status,  // active low
  input  ft_buf_pkg::ep_stat_t [ft_buf_pkg::NUM_EP-1:0] i_stat,
  output logic                                 o_grant,
  output ft_buf_pkg::ep_t                      o_ep,
  output ft_bus_pkg::dir_t                     o_dir
);

  logic [ft_buf_pkg::NUM_EP-1:0] rd_req;
  logic [ft_buf_pkg::NUM_EP-1:0] wr_req;
  ft_buf_pkg::ep_t               last_ep;  // last served endpoint
  ft_buf_pkg::ep_t               nxt_ep;
  ft_bus_pkg::dir_t              nxt_dir;
  logic                          found;

  // slave data and an empty buffer ask for a read
  // slave room and buffered words ask for a write
  always_comb begin
    for (int i = 0; i < ft_buf_pkg::NUM_EP; i++) begin
      rd_req[i] = ~i_slv_status[i] & i_stat[i].empty;
      wr_req[i] = ~i_slv_status[ft_buf_pkg::NUM_EP+i] & ~i_stat[i].empty;
    end
  end

  // search starts one past the last grant
  always_comb begin
    ft_buf_pkg::ep_t idx;
    found   = 1'b0;
    nxt_ep  = last_ep;
    nxt_dir = ft_bus_pkg::DIR_RD;
    for (int i = 1; i <= ft_buf_pkg::NUM_EP; i++) begin
      idx = last_ep + ft_buf_pkg::ep_t'(i);
      if (!found && (rd_req[idx] || wr_req[idx])) begin
        found   = 1'b1;
        nxt_ep  = idx;
        nxt_dir = wr_req[idx] ? ft_bus_pkg::DIR_WR : ft_bus_pkg::DIR_RD;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_grant <= 1'b0;
      last_ep <= '1;  // ep 0 gets first turn
      o_dir   <= ft_bus_pkg::DIR_RD;
    end else begin
      o_grant <= i_idle && !o_grant && found;  // FSM leaves idle a cycle later
      if (i_idle && !o_grant && found) begin
        last_ep <= nxt_ep;
        o_dir   <= nxt_dir;
      end
    end
  end

  assign o_ep = last_ep;  // held for the whole bus cycle

  // grant only while the bus FSM sits in idle, and it must leave idle next
  a_grant_idle: assert property (@(posedge i_clk) disable iff (i_reset)
    o_grant |-> i_idle ##1 !i_idle)
    else $error("grant outside idle bus state");

endmodule

// ==== design/fifo_mst_fsm.sv ====
/* bus cycle FSM for the FIFO master
   runs the command, turnaround, read and write phases of one burst */

module fifo_mst_fsm (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_grant,
  input  ft_buf_pkg::ep_t      i_ep,
  input  ft_bus_pkg::dir_t     i_dir,
  input  ft_buf_pkg::ep_stat_t i_stat,   // status of the current endpoint
  input  logic                 i_rxf_n,
  input  logic                 i_txe_n,
  output logic                 o_idle,
  output ft_buf_pkg::ep_t      o_cur_ep,
  output logic                 o_push,
  output logic                 o_pop,
  output logic                 o_cmd_sel,
  output logic                 o_data_oe,
  output logic                 o_wr_n,
  output logic                 o_rd_n,
  output logic                 o_oe_n
);

  typedef enum logic [2:0] {
    IDLE,
    CMD,
    TURN,
    RD_DATA,
    WR_PRE,
    WR_DATA
  } state_t;

  state_t           state;
  state_t           nxt_state;
  ft_buf_pkg::ep_t  ep_q;
  ft_bus_pkg::dir_t dir_q;
  logic             rd_act;
  logic             wr_act;

  // ----------------------------------------------------------------------
  // data phase qualifiers
  // ----------------------------------------------------------------------
  // strobes drop as soon as the buffer fills or drains
  assign rd_act = (state == RD_DATA) && !i_stat.full;
  assign wr_act = (state == WR_DATA) && !i_stat.empty;

  assign o_push = rd_act && !i_rxf_n;  // word captured this edge
  assign o_pop  = wr_act && !i_txe_n;  // head word taken by slave

  // ----------------------------------------------------------------------
  // state register and endpoint latch
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= IDLE;
      ep_q  <= '0;
      dir_q <= ft_bus_pkg::DIR_RD;
    end else begin
      state <= nxt_state;
      if (i_grant) begin
        ep_q  <= i_ep;
        dir_q <= i_dir;
      end
    end
  end

  always_comb begin
    nxt_state = state;
    case (state)
      IDLE: begin
        if (i_grant) nxt_state = CMD;
      end
      CMD: begin
        nxt_state = (dir_q == ft_bus_pkg::DIR_WR) ? WR_PRE : TURN;
      end
      TURN:    nxt_state = RD_DATA;  // bus released one cycle
      RD_DATA: begin
        if (!rd_act || i_rxf_n) nxt_state = IDLE;
      end
      WR_PRE:  nxt_state = WR_DATA;  // RAM fetches the head word
      WR_DATA: begin
        // an unaccepted word stays at the head for the next burst
        if (!wr_act || i_txe_n) nxt_state = IDLE;
      end
      default: nxt_state = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // bus strobes
  // ----------------------------------------------------------------------
  assign o_idle    = (state == IDLE);
  assign o_cur_ep  = ep_q;
  assign o_cmd_sel = (state == CMD);
  assign o_data_oe = o_cmd_sel || wr_act;
  assign o_wr_n    = !(o_cmd_sel || wr_act);
  assign o_rd_n    = !rd_act;
  assign o_oe_n    = !rd_act;

  // checks against the endpoint status seen through the top-level mux
  a_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
    o_push |-> !i_stat.full)
    else $error("push into a full buffer");

  a_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    o_pop |-> !i_stat.empty)
    else $error("pop from an empty buffer");

  a_rd_wr: assert property (@(posedge i_clk) disable iff (i_reset)
    !(!o_rd_n && !o_wr_n))
    else $error("read and write strobes both low");

endmodule

// ==== design/fifo_ep_mst.sv ====
/* pointer block for one endpoint buffer
   tracks fill level and drives the shared RAM address when selected */

module fifo_ep_mst #(
  parameter ft_buf_pkg::ep_t EP_ID = '0
) (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  ft_buf_pkg::ep_t      i_sel_ep,
  input  logic                 i_push,
  input  logic                 i_pop,
  input  logic                 i_prefetch,  // bus burst running
  output ft_buf_pkg::ep_stat_t o_stat,
  output ft_buf_pkg::ram_adr_t o_ram_adr
);

  localparam int AW = ft_buf_pkg::EP_AW;

  logic             sel;
  logic             push;
  logic             pop;
  ft_buf_pkg::ptr_t wr_ptr;
  ft_buf_pkg::ptr_t rd_ptr;
  ft_buf_pkg::ptr_t rd_nxt;

  assign sel  = (i_sel_ep == EP_ID) && i_prefetch;
  assign push = sel && i_push;
  assign pop  = sel && i_pop;

  // ----------------------------------------------------------------------
  // pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // equal index with opposite wrap bits means full
  assign o_stat.empty = (wr_ptr == rd_ptr);
  assign o_stat.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                        (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // ----------------------------------------------------------------------
  // RAM address
  // ----------------------------------------------------------------------
  // look one word ahead on pop so the registered read follows the head
  assign rd_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

  always_comb begin
    if (!sel) begin
      o_ram_adr = '0;  // ORed with the other endpoints at the top
    end else if (push) begin
      o_ram_adr = {EP_ID, wr_ptr[AW-1:0]};
    end else begin
      o_ram_adr = {EP_ID, rd_nxt[AW-1:0]};
    end
  end

endmodule

// ==== design/fifo_mst_ram.sv ====
/* shared buffer RAM for all endpoints
   byte-lane writes, be field stored with any write, registered read */

module fifo_mst_ram (
  input  logic                  i_clk,
  input  ft_bus_pkg::be_t       i_we,     // one strobe per byte lane
  input  ft_buf_pkg::ram_adr_t  i_adr,
  input  ft_bus_pkg::bus_word_t i_wdata,
  output ft_bus_pkg::bus_word_t o_rdata
);

  ft_bus_pkg::bus_word_t mem [ft_buf_pkg::RAM_WORDS];

  // ----------------------------------------------------------------------
  // write port
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < ft_bus_pkg::BE_W; b++) begin
      if (i_we[b]) mem[i_adr].data[8*b +: 8] <= i_wdata.data[8*b +: 8];
    end
    if (|i_we) mem[i_adr].be <= i_wdata.be;  // enables go back out with the word
  end

  // registered read port with one cycle latency
  always_ff @(posedge i_clk) begin
    o_rdata <= mem[i_adr];
  end

endmodule

// ==== design/fifo_mst_top.sv ====
/* FT600 style FIFO master in loopback
   arbiter, bus FSM, shared buffer RAM and four endpoint pointer blocks */

module fifo_mst_top (
  input  logic                            i_clk,
  input  logic                            i_reset,
  input  ft_bus_pkg::data_t               i_data,
  input  ft_bus_pkg::be_t                 i_be,
  input  logic                            i_rxf_n,
  input  logic                            i_txe_n,
  input  logic [2*ft_buf_pkg::NUM_EP-1:0] i_slv_status,
  output ft_bus_pkg::data_t               o_data,
  output ft_bus_pkg::be_t                 o_be,
  output logic                            o_data_oe,
  output logic                            o_wr_n,
  output logic                            o_rd_n,
  output logic                            o_oe_n,
  output logic [ft_buf_pkg::NUM_EP-1:0]   o_buf_empty,
  output logic [ft_buf_pkg::NUM_EP-1:0]   o_buf_full
);

  ft_buf_pkg::ep_stat_t [ft_buf_pkg::NUM_EP-1:0] ep_stat;
  ft_buf_pkg::ram_adr_t  ep_adr [ft_buf_pkg::NUM_EP];
  ft_buf_pkg::ram_adr_t  ram_adr;
  ft_buf_pkg::ep_stat_t  cur_stat;
  ft_buf_pkg::ep_t       arb_ep;
  ft_buf_pkg::ep_t       cur_ep;
  ft_bus_pkg::dir_t      arb_dir;
  ft_bus_pkg::bus_word_t ram_rdata;
  ft_bus_pkg::bus_word_t ram_wdata;
  ft_bus_pkg::cmd_t      cmd_word;
  logic                  grant;
  logic                  idle;
  logic                  push;
  logic                  pop;
  logic                  cmd_sel;

  // ----------------------------------------------------------------------
  // muxes and glue
  // ----------------------------------------------------------------------
  assign cur_stat = ep_stat[cur_ep];  // status of the endpoint on the bus

  always_comb begin
    ram_adr = '0;
    for (int i = 0; i < ft_buf_pkg::NUM_EP; i++) begin
      ram_adr = ram_adr | ep_adr[i];  // only the selected block is non-zero
    end
  end

  always_comb begin
    for (int i = 0; i < ft_buf_pkg::NUM_EP; i++) begin
      o_buf_empty[i] = ep_stat[i].empty;
      o_buf_full[i]  = ep_stat[i].full;
    end
  end

  assign cmd_word  = '{rsvd_hi: '0, rsvd_lo: '0, dir: arb_dir, ep: cur_ep};
  assign ram_wdata = '{data: i_data, be: i_be};

  assign o_data = cmd_sel ? ft_bus_pkg::data_t'(cmd_word) : ram_rdata.data;
  assign o_be   = cmd_sel ? '1 : ram_rdata.be;

  // ----------------------------------------------------------------------
  // blocks
  // ----------------------------------------------------------------------
  fifo_mst_arb u_arb (
    .i_clk(i_clk), .i_reset(i_reset), .i_idle(idle),
    .i_slv_status(i_slv_status), .i_stat(ep_stat),
    .o_grant(grant), .o_ep(arb_ep), .o_dir(arb_dir)
  );

  fifo_mst_fsm u_fsm (
    .i_clk(i_clk), .i_reset(i_reset), .i_grant(grant),
    .i_ep(arb_ep), .i_dir(arb_dir), .i_stat(cur_stat),
    .i_rxf_n(i_rxf_n), .i_txe_n(i_txe_n),
    .o_idle(idle), .o_cur_ep(cur_ep), .o_push(push), .o_pop(pop),
    .o_cmd_sel(cmd_sel), .o_data_oe(o_data_oe),
    .o_wr_n(o_wr_n), .o_rd_n(o_rd_n), .o_oe_n(o_oe_n)
  );

  fifo_mst_ram u_ram (
    .i_clk(i_clk), .i_we({ft_bus_pkg::BE_W{push}} & i_be),
    .i_adr(ram_adr), .i_wdata(ram_wdata), .o_rdata(ram_rdata)
  );

  for (genvar g = 0; g < ft_buf_pkg::NUM_EP; g++) begin : g_ep
    fifo_ep_mst #(.EP_ID(ft_buf_pkg::ep_t'(g))) u_ep (
      .i_clk(i_clk), .i_reset(i_reset), .i_sel_ep(cur_ep),
      .i_push(push), .i_pop(pop), .i_prefetch(!idle),
      .o_stat(ep_stat[g]), .o_ram_adr(ep_adr[g])
    );
  end

endmodule

// ==== verif/clk_gen.sv ====
/* testbench clock with a 20 ns period
   reset held high for the first 8 rising edges */

module clk_gen (
  output logic o_clk,
  output logic o_reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk   = 1'b0;
    o_reset = 1'b1;
    forever #10 o_clk = ~o_clk;
  end

  initial begin
    repeat (8) @(posedge o_clk);
    @(negedge o_clk);
    o_reset <= 1'b0;  // released on a falling edge like the other inputs
  end

endmodule

// ==== verif/tb_fifo_mst_top.sv ====
/* testbench for the FIFO master that plays the slave side of the bus
   and checks command words, loopback data and buffer flags */

module tb_fifo_mst_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS    = 20;
  localparam int NUM_WORDS = 19;  // payload words over all tests
  localparam int MAX_WAIT  = 64;  // cycles until a missing command is reported

  logic                            clk;
  logic                            reset;
  ft_bus_pkg::data_t               data_in;
  ft_bus_pkg::data_t               data_out;
  ft_bus_pkg::be_t                 be_in;
  ft_bus_pkg::be_t                 be_out;
  logic                            rxf_n;
  logic                            txe_n;
  logic [2*ft_buf_pkg::NUM_EP-1:0] slv_status;  // active low
  logic                            data_oe;
  logic                            wr_n;
  logic                            rd_n;
  logic                            oe_n;
  logic [ft_buf_pkg::NUM_EP-1:0]   buf_empty;
  logic [ft_buf_pkg::NUM_EP-1:0]   buf_full;
  ft_bus_pkg::bus_word_t           exp_q [ft_buf_pkg::NUM_EP][$];  // words held per endpoint
  ft_buf_pkg::ep_t                 last_ep;  // last endpoint the master served
  int                              checks;
  int                              errors;

  clk_gen u_clk (.o_clk(clk), .o_reset(reset));

  fifo_mst_top u_dut (
    .i_clk(clk), .i_reset(reset), .i_data(data_in), .i_be(be_in),
    .i_rxf_n(rxf_n), .i_txe_n(txe_n), .i_slv_status(slv_status),
    .o_data(data_out), .o_be(be_out), .o_data_oe(data_oe),
    .o_wr_n(wr_n), .o_rd_n(rd_n), .o_oe_n(oe_n),
    .o_buf_empty(buf_empty), .o_buf_full(buf_full)
  );

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input string what, input ft_bus_pkg::bus_word_t got,
                            input ft_bus_pkg::bus_word_t exp);
    ft_bus_pkg::data_t mask;
    for (int b = 0; b < ft_bus_pkg::BE_W; b++) begin
      mask[8*b +: 8] = {8{exp.be[b]}};  // disabled lanes keep old RAM bytes
    end
    checks++;
    if (got.be !== exp.be || (got.data & mask) !== (exp.data & mask)) begin
      errors++;
      $display("ERR %0t: %s got %h/%h exp %h/%h", $time, what, got.data, got.be,
               exp.data, exp.be);
    end
  endtask

  task automatic check_cmd(input ft_bus_pkg::cmd_t got, input ft_bus_pkg::be_t got_be,
                           input ft_bus_pkg::cmd_t exp);
    checks++;
    if (got !== exp || got_be !== '1) begin
      errors++;
      $display("ERR %0t: command got %h be %h exp %h", $time, got, got_be, exp);
    end
  endtask

  task automatic check_stat(input string what, input logic [ft_buf_pkg::NUM_EP-1:0] got,
                            input logic [ft_buf_pkg::NUM_EP-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b exp %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // slave model
  // ----------------------------------------------------------------------
  function automatic ft_bus_pkg::bus_word_t new_word();
    ft_bus_pkg::bus_word_t w;
    w.data = $urandom();
    w.be   = ft_bus_pkg::be_t'($urandom_range(15, 1));  // at least one lane
    return w;
  endfunction

  // next requester after the last served endpoint
  function automatic ft_buf_pkg::ep_t pick_next(input ft_buf_pkg::ep_t last,
                                                input logic [ft_buf_pkg::NUM_EP-1:0] req);
    ft_buf_pkg::ep_t ep;
    for (int i = 1; i <= ft_buf_pkg::NUM_EP; i++) begin
      ep = ft_buf_pkg::ep_t'(int'(last) + i);
      if (req[ep]) return ep;
    end
    return last;
  endfunction

  task automatic wait_cmd(input ft_buf_pkg::ep_t ep, input ft_bus_pkg::dir_t dir);
    ft_bus_pkg::cmd_t exp;
    int               n;
    exp = '{rsvd_hi: '0, rsvd_lo: '0, dir: dir, ep: ep};
    n = 0;
    @(negedge clk);
    while (!(data_oe && !wr_n) && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!(data_oe && !wr_n)) begin
      errors++;
      $display("no command word from the master for endpoint %0d", ep);
    end else begin
      check_cmd(ft_bus_pkg::cmd_t'(data_out), be_out, exp);
    end
    last_ep = ep;
  endtask

  task automatic read_burst(input ft_buf_pkg::ep_t ep, input int count);
    ft_bus_pkg::bus_word_t w;
    int                    sent;
    sent = 0;
    wait_cmd(ep, ft_bus_pkg::DIR_RD);
    slv_status[ep] = 1'b1;
    while (sent < count) begin
      @(negedge clk);
      if (!rd_n) begin  // word driven now is taken at the next rising edge
        check_stat("strobes during read", {wr_n, rd_n, oe_n, data_oe}, 4'b1000);
        w = new_word();
        exp_q[ep].push_back(w);
        data_in = w.data;
        be_in   = w.be;
        rxf_n   = 1'b0;
        sent++;
      end
    end
    @(negedge clk);
    rxf_n = 1'b1;
  endtask

  task automatic write_burst(input ft_buf_pkg::ep_t ep, input int limit);
    ft_bus_pkg::bus_word_t got;
    int                    taken;
    taken = 0;
    wait_cmd(ep, ft_bus_pkg::DIR_WR);
    slv_status[ft_buf_pkg::NUM_EP + ep] = 1'b1;
    txe_n = 1'b0;
    @(negedge clk);  // WR_PRE
    @(negedge clk);
    while (data_oe && !wr_n && taken < limit) begin
      got = '{data: data_out, be: be_out};
      if (exp_q[ep].size() == 0) begin
        errors++;
        $display("endpoint %0d sent a word that was never read in", ep);
      end else begin
        check_word($sformatf("ep %0d write", ep), got, exp_q[ep].pop_front());
      end
      taken++;
      @(negedge clk);
    end
    txe_n = 1'b1;  // a word on the bus now stays at the head
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic reset_state();
    check_stat("strobes after reset", {wr_n, rd_n, oe_n, data_oe}, 4'b1110);
    check_stat("empty flags after reset", buf_empty, 4'b1111);
    check_stat("full flags after reset", buf_full, 4'b0000);
  endtask

  task automatic full_read();
    slv_status[2] = 1'b0;
    read_burst(2, ft_buf_pkg::EP_DEPTH);
    check_stat("full flags after full read", buf_full, 4'b0100);
  endtask

  task automatic loopback_write();
    slv_status[ft_buf_pkg::NUM_EP + 2] = 1'b0;
    write_burst(2, ft_buf_pkg::EP_DEPTH);
    check_stat("empty flags after loopback", buf_empty, 4'b1111);
  endtask

  task automatic back_pressure();
    slv_status[0] = 1'b0;
    read_burst(0, 3);
    check_stat("empty flags after short read", buf_empty, 4'b1110);
    check_stat("full flags after short read", buf_full, 4'b0000);
    slv_status[ft_buf_pkg::NUM_EP] = 1'b0;
    write_burst(0, 1);
    check_stat("empty flags after stalled write", buf_empty, 4'b1110);
    slv_status[ft_buf_pkg::NUM_EP] = 1'b0;
    write_burst(0, ft_buf_pkg::EP_DEPTH);  // the two words left behind
    check_stat("empty flags after second write", buf_empty, 4'b1111);
  endtask

  task automatic round_robin();
    logic [ft_buf_pkg::NUM_EP-1:0] req;
    ft_buf_pkg::ep_t               ep;
    req = 4'b1010;
    slv_status[1] = 1'b0;  // data on ep 1 and ep 3 together
    slv_status[3] = 1'b0;
    repeat (2) begin
      ep = pick_next(last_ep, req);
      read_burst(ep, 4);
      req[ep] = 1'b0;
    end
    req = 4'b1010;
    slv_status[ft_buf_pkg::NUM_EP + 1] = 1'b0;
    slv_status[ft_buf_pkg::NUM_EP + 3] = 1'b0;
    repeat (2) begin
      ep = pick_next(last_ep, req);
      write_burst(ep, ft_buf_pkg::EP_DEPTH);
      req[ep] = 1'b0;
    end
    check_stat("empty flags after round robin", buf_empty, 4'b1111);
  endtask

  initial begin
    #(NUM_WORDS * 40 * CLK_NS + 2000);
    $display("timeout: the tests did not finish in time");
    $display("test failed");
    $finish;
  end

  initial begin
    checks     = 0;
    errors     = 0;
    last_ep    = '1;  // ep 0 is served first after reset
    data_in    = '0;
    be_in      = '0;
    rxf_n      = 1'b1;
    txe_n      = 1'b1;
    slv_status = '1;
    void'($urandom(32'he928));
    @(negedge clk);
    while (reset) @(negedge clk);
    reset_state();
    full_read();
    loopback_write();
    back_pressure();
    round_robin();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/ft_buf_pkg.sv
design/ft_bus_pkg.sv
design/fifo_mst_arb.sv
design/fifo_mst_fsm.sv
design/fifo_ep_mst.sv
design/fifo_mst_ram.sv
design/fifo_mst_top.sv
verif/clk_gen.sv
verif/tb_fifo_mst_top.sv

// ==== run.sh ====
#!/bin/sh
# build the FIFO master testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f list.f --top-module tb_fifo_mst_top -o tb_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
